//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int SHAMT_W  = $clog2(XLEN);    // Shift amount field width

    typedef logic [XLEN-1:0] t_rv_reg_data;
    typedef logic [4:0]      t_reg_idx;

    localparam t_rv_reg_data ILLEGAL_RESULT = 32'hDEADBEEF;

    typedef enum logic [3:0] {
        U_ADD,
        U_SUB,
        U_AND,
        U_OR,
        U_XOR,
        U_SLL,
        U_SRL,
        U_SRA,
        U_SLT,
        U_SLTU,
        U_ILLEGAL
    } t_uop;

    typedef enum logic {
        OP_REG,
        OP_IMM
    } t_optype;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 values shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // SUB and SRA/SRAI

    typedef struct packed {
        logic [6:0] funct7;
        t_reg_idx   rs2;
        t_reg_idx   rs1;
        logic [2:0] funct3;
        t_reg_idx   rd;
        logic [6:0] opcode;
    } t_r_fmt;

    typedef struct packed {
        logic [11:0] imm12;
        t_reg_idx    rs1;
        logic [2:0]  funct3;
        t_reg_idx    rd;
        logic [6:0]  opcode;
    } t_i_fmt;

    // One word, read as R or I format depending on the field
    typedef union packed {
        t_r_fmt r;
        t_i_fmt i;
    } t_rv_instr_word;

endpackage

//--- src/exec_bus_pkg.sv
package exec_bus_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } t_apb_req;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } t_apb_rsp;

    // APB address map
    localparam logic [11:0] ADDR_ISSUE    = 12'h000;
    localparam logic [11:0] ADDR_STATUS   = 12'h004;
    localparam logic [11:0] ADDR_REG_BASE = 12'h080;    // Register r at base + 4*r

    typedef struct packed {
        rv_isa_pkg::t_optype optype;
    } t_src;

    typedef struct packed {
        logic                     valid;
        rv_isa_pkg::t_uop         uop;
        logic                     illegal;
        rv_isa_pkg::t_reg_idx     rd;
        t_src                     src2;
        rv_isa_pkg::t_rv_reg_data imm32;
    } t_uinstr;

endpackage

//--- src/apb_issue_port.sv
`timescale 1ns/100ps

module apb_issue_port (
    input  logic                       clk,
    input  logic                       reset,
    input  exec_bus_pkg::t_apb_req     apb_req,
    output exec_bus_pkg::t_apb_rsp     apb_rsp,
    output rv_isa_pkg::t_rv_instr_word issue_word,
    output logic                       issue_valid,
    input  logic                       busy_rd1,
    input  logic                       ex1_illegal,
    output rv_isa_pkg::t_reg_idx       host_raddr,
    input  rv_isa_pkg::t_rv_reg_data   host_rdata
);
    import rv_isa_pkg::*;
    import exec_bus_pkg::*;

    logic access;
    logic is_issue;
    logic is_status;
    logic is_reg;
    logic addr_err;
    logic in_flight;
    logic done;
    logic illegal_flag;

    assign access    = apb_req.psel & apb_req.penable;
    assign is_issue  = apb_req.paddr == ADDR_ISSUE;
    assign is_status = apb_req.paddr == ADDR_STATUS;
    assign is_reg    = (apb_req.paddr >= ADDR_REG_BASE)
                     && (apb_req.paddr < ADDR_REG_BASE + 12'(NUM_REGS * 4))
                     && (apb_req.paddr[1:0] == 2'b00);

    // Writes go only to ISSUE/STATUS, reads only to STATUS and the register window
    assign addr_err  = apb_req.pwrite ? !(is_issue || is_status) : !(is_status || is_reg);
    assign in_flight = issue_valid | busy_rd1;
    assign host_raddr = t_reg_idx'(apb_req.paddr[6:2]);

    always_comb begin
        apb_rsp = '0;
        // Good reads hold off until the pipeline has drained
        apb_rsp.pready = access & (apb_req.pwrite | addr_err | !in_flight);
        apb_rsp.pslverr = apb_rsp.pready & addr_err;
        if (!apb_req.pwrite && is_status)
            apb_rsp.prdata = {{(XLEN-1){1'b0}}, illegal_flag};
        else if (!apb_req.pwrite && is_reg)
            apb_rsp.prdata = host_rdata;
    end

    assign done = apb_rsp.pready & !addr_err;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid  <= 1'b0;
            illegal_flag <= 1'b0;
        end else begin
            issue_valid <= done & apb_req.pwrite & is_issue;    // One-cycle pulse
            if (ex1_illegal)
                illegal_flag <= 1'b1;
            else if (done && apb_req.pwrite && is_status)
                illegal_flag <= 1'b0;    // Any STATUS write clears it
        end
    end

    always_ff @(posedge clk) begin
        if (done && apb_req.pwrite && is_issue)
            issue_word <= apb_req.pwdata;
    end

    a_penable_in_psel: assert property (@(posedge clk) disable iff (reset)
        $rose(apb_req.penable) |-> apb_req.psel);

    a_req_stable_wait: assert property (@(posedge clk) disable iff (reset)
        (access && !apb_rsp.pready) |=> $stable(apb_req));

endmodule

//--- src/instr_decode_unit.sv
`timescale 1ns/100ps

module instr_decode_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  rv_isa_pkg::t_rv_instr_word issue_word,
    input  logic                       issue_valid,
    output exec_bus_pkg::t_uinstr      uinstr_rd1
);
    import rv_isa_pkg::*;
    import exec_bus_pkg::*;

    t_uinstr uinstr_rd0;
    t_uop    uop;
    logic    legal;

    // Encodings in the supported set
    always_comb begin
        legal = 1'b0;
        if (issue_word.r.opcode == OPC_OP)
            legal = (issue_word.r.funct7 == F7_BASE)
                 || (issue_word.r.funct7 == F7_ALT
                     && issue_word.r.funct3 inside {F3_ADD_SUB, F3_SRL_SRA});
        else if (issue_word.i.opcode == OPC_OP_IMM)
            legal = !(issue_word.i.funct3 inside {F3_SLL, F3_SRL_SRA})
                 || (issue_word.r.funct7 == F7_BASE)
                 || (issue_word.r.funct7 == F7_ALT && issue_word.i.funct3 == F3_SRL_SRA);
    end

    always_comb begin
        uop = U_ILLEGAL;
        uinstr_rd0 = '0;
        uinstr_rd0.rd = issue_word.r.rd;
        uinstr_rd0.imm32 = {{(XLEN-12){issue_word.i.imm12[11]}}, issue_word.i.imm12};

        case (issue_word.r.opcode)
            OPC_OP: begin
                uinstr_rd0.src2.optype = OP_REG;
                if (issue_word.r.funct7 == F7_BASE) begin
                    case (issue_word.r.funct3)
                        F3_ADD_SUB: uop = U_ADD;
                        F3_SLL:     uop = U_SLL;
                        F3_SLT:     uop = U_SLT;
                        F3_SLTU:    uop = U_SLTU;
                        F3_XOR:     uop = U_XOR;
                        F3_SRL_SRA: uop = U_SRL;
                        F3_OR:      uop = U_OR;
                        F3_AND:     uop = U_AND;
                        default:    uop = U_ILLEGAL;
                    endcase
                end else if (issue_word.r.funct7 == F7_ALT) begin
                    if (issue_word.r.funct3 == F3_ADD_SUB)
                        uop = U_SUB;
                    else if (issue_word.r.funct3 == F3_SRL_SRA)
                        uop = U_SRA;
                end
            end
            OPC_OP_IMM: begin
                uinstr_rd0.src2.optype = OP_IMM;
                case (issue_word.i.funct3)
                    F3_ADD_SUB: uop = U_ADD;
                    F3_SLT:     uop = U_SLT;
                    F3_SLTU:    uop = U_SLTU;
                    F3_XOR:     uop = U_XOR;
                    F3_OR:      uop = U_OR;
                    F3_AND:     uop = U_AND;
                    // Shift immediates keep funct7 in the upper imm bits
                    F3_SLL:     if (issue_word.r.funct7 == F7_BASE) uop = U_SLL;
                    F3_SRL_SRA: begin
                        if (issue_word.r.funct7 == F7_BASE)
                            uop = U_SRL;
                        else if (issue_word.r.funct7 == F7_ALT)
                            uop = U_SRA;
                    end
                    default:    uop = U_ILLEGAL;
                endcase
                if (issue_word.i.funct3 inside {F3_SLL, F3_SRL_SRA})
                    uinstr_rd0.imm32 = XLEN'(issue_word.i.imm12[SHAMT_W-1:0]);
            end
            default: uop = U_ILLEGAL;
        endcase

        uinstr_rd0.uop = uop;
        uinstr_rd0.illegal = !legal;
        uinstr_rd0.valid = 1'b1;
        if (!issue_valid)
            uinstr_rd0 = '0;    // Empty slot carries no flags downstream
    end

    always_ff @(posedge clk) begin
        if (reset)
            uinstr_rd1 <= '0;
        else
            uinstr_rd1 <= uinstr_rd0;
    end

    // The top uses the illegal bit alone as a qualified event
    a_illegal_uop: assert property (@(posedge clk) disable iff (reset)
        uinstr_rd1.illegal |-> (uinstr_rd1.valid && uinstr_rd1.uop == U_ILLEGAL));

endmodule

//--- src/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                       clk,
    input  logic                       reset,
    input  rv_isa_pkg::t_rv_instr_word issue_word,
    input  exec_bus_pkg::t_uinstr      uinstr_ex1,
    input  rv_isa_pkg::t_rv_reg_data   result_ex1,
    output rv_isa_pkg::t_rv_reg_data   rddatas_rd1 [2],
    input  rv_isa_pkg::t_reg_idx       host_raddr,
    output rv_isa_pkg::t_rv_reg_data   host_rdata
);
    import rv_isa_pkg::*;

    t_rv_reg_data regs [NUM_REGS];
    t_reg_idx     src_idx [2];
    logic         wr_en;

    assign wr_en = uinstr_ex1.valid & !uinstr_ex1.illegal & (uinstr_ex1.rd != '0);
    assign src_idx[0] = issue_word.i.rs1;
    assign src_idx[1] = issue_word.r.rs2;
    assign host_rdata = regs[host_raddr];

    // Write-through so a dependent op issued right behind sees the new value
    function automatic t_rv_reg_data read_fwd(t_reg_idx idx);
        if (wr_en && idx == uinstr_ex1.rd)
            return result_ex1;
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[uinstr_ex1.rd] <= result_ex1;
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++)
            rddatas_rd1[p] <= read_fwd(src_idx[p]);
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

//--- src/exe.sv
`timescale 1ns/100ps

module exe (
    input  logic                     clk,
    input  logic                     reset,
    input  exec_bus_pkg::t_uinstr    uinstr_rd1,
    input  rv_isa_pkg::t_rv_reg_data rddatas_rd1 [2],
    output exec_bus_pkg::t_uinstr    uinstr_ex1,
    output rv_isa_pkg::t_rv_reg_data result_ex1
);
    import rv_isa_pkg::*;

    t_rv_reg_data       src1val_ex0;
    t_rv_reg_data       src2val_ex0;
    t_rv_reg_data       result_ex0;
    logic [SHAMT_W-1:0] shamt_ex0;

    assign src1val_ex0 = rddatas_rd1[0];
    assign src2val_ex0 = (uinstr_rd1.src2.optype == OP_IMM) ? uinstr_rd1.imm32 : rddatas_rd1[1];
    assign shamt_ex0   = src2val_ex0[SHAMT_W-1:0];

    always_comb begin
        case (uinstr_rd1.uop)
            U_ADD:   result_ex0 = src1val_ex0 + src2val_ex0;
            U_SUB:   result_ex0 = src1val_ex0 - src2val_ex0;
            U_AND:   result_ex0 = src1val_ex0 & src2val_ex0;
            U_OR:    result_ex0 = src1val_ex0 | src2val_ex0;
            U_XOR:   result_ex0 = src1val_ex0 ^ src2val_ex0;
            U_SLL:   result_ex0 = src1val_ex0 << shamt_ex0;
            U_SRL:   result_ex0 = src1val_ex0 >> shamt_ex0;
            U_SRA:   result_ex0 = $signed(src1val_ex0) >>> shamt_ex0;
            U_SLT:   result_ex0 = XLEN'($signed(src1val_ex0) < $signed(src2val_ex0));
            U_SLTU:  result_ex0 = XLEN'(src1val_ex0 < src2val_ex0);
            default: result_ex0 = ILLEGAL_RESULT;    // U_ILLEGAL
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            uinstr_ex1 <= '0;
        else
            uinstr_ex1 <= uinstr_rd1;
    end

    always_ff @(posedge clk) begin
        result_ex1 <= result_ex0;
    end

    a_uop_known: assert property (@(posedge clk) disable iff (reset)
        uinstr_rd1.valid |-> !$isunknown(uinstr_rd1.uop));

endmodule

//--- src/rv_exec_top.sv
`timescale 1ns/100ps

module rv_exec_top (
    input  logic                   clk,
    input  logic                   reset,
    input  exec_bus_pkg::t_apb_req apb_req,
    output exec_bus_pkg::t_apb_rsp apb_rsp
);
    import rv_isa_pkg::*;
    import exec_bus_pkg::*;

    t_rv_instr_word issue_word;
    logic           issue_valid;
    logic           busy_rd1;
    t_uinstr        uinstr_rd1;
    t_uinstr        uinstr_ex1;
    t_rv_reg_data   rddatas_rd1 [2];
    t_rv_reg_data   result_ex1;
    t_reg_idx       host_raddr;
    t_rv_reg_data   host_rdata;

    assign busy_rd1 = uinstr_rd1.valid | uinstr_ex1.valid;    // Anything past issue

    apb_issue_port u_port (
        .clk         (clk),
        .reset       (reset),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .issue_word  (issue_word),
        .issue_valid (issue_valid),
        .busy_rd1    (busy_rd1),
        .ex1_illegal (uinstr_ex1.illegal),
        .host_raddr  (host_raddr),
        .host_rdata  (host_rdata)
    );

    instr_decode_unit u_decode (
        .clk         (clk),
        .reset       (reset),
        .issue_word  (issue_word),
        .issue_valid (issue_valid),
        .uinstr_rd1  (uinstr_rd1)
    );

    reg_file u_reg_file (
        .clk         (clk),
        .reset       (reset),
        .issue_word  (issue_word),
        .uinstr_ex1  (uinstr_ex1),
        .result_ex1  (result_ex1),
        .rddatas_rd1 (rddatas_rd1),
        .host_raddr  (host_raddr),
        .host_rdata  (host_rdata)
    );

    exe u_exe (
        .clk         (clk),
        .reset       (reset),
        .uinstr_rd1  (uinstr_rd1),
        .rddatas_rd1 (rddatas_rd1),
        .uinstr_ex1  (uinstr_ex1),
        .result_ex1  (result_ex1)
    );

endmodule

//--- test/tb_rv_exec_top.sv
`timescale 1ns/100ps

module tb_rv_exec_top;
    import exec_bus_pkg::*;

    localparam int    CLK_PERIOD    = 10;
    localparam int    RESET_CYCLES  = 10;
    localparam int    CYCLES_PER_OP = 20;    // Budget per trace line
    localparam string TRACE_FILE    = "test/exec_trace.txt";

    // One trace line
    typedef struct packed {
        logic [8*20-1:0] name;
        logic            is_write;
        logic [11:0]     addr;
        logic [31:0]     data;
        logic [31:0]     exp_data;
        logic            exp_err;
    } t_trace_op;

    logic      clk;
    logic      reset;
    t_apb_req  apb_req;
    t_apb_rsp  apb_rsp;
    t_trace_op ops[$];
    logic      loaded;
    integer    seed;
    int        errors;
    int        failed_tests;

    rv_exec_top UUT (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic load_trace();
        int              fd;
        int              n;
        string           line;
        logic [8*20-1:0] name;
        logic [7:0]      op_c;
        logic [31:0]     addr;
        logic [31:0]     data;
        logic [31:0]     exp_data;
        logic [31:0]     exp_err;
        t_trace_op       op;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
            return;
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#")
                continue;    // Column header
            n = $sscanf(line, "%s %s %h %h %h %h", name, op_c, addr, data, exp_data, exp_err);
            if (n == 6) begin
                op.name     = name;
                op.is_write = (op_c == "W");
                op.addr     = addr[11:0];
                op.data     = data;
                op.exp_data = exp_data;
                op.exp_err  = exp_err[0];
                ops.push_back(op);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_value(input logic [8*20-1:0] name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %0s (%0s): expected %h, actual %h",
                     name, what, expected, actual);
            errors++;
        end
    endtask

    // Setup then access phase; returns after the completing rising edge
    task automatic apb_transfer(input t_trace_op op, output logic [31:0] rdata,
                                output logic err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = op.is_write;
        apb_req.paddr   = op.addr;
        apb_req.pwdata  = op.data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        while (!apb_rsp.pready) begin    // Wait states
            @(negedge clk);
            #1;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
    endtask

    task automatic run_op(input t_trace_op op);
        logic [31:0] rdata;
        logic        err;
        int          errors_before;
        int          idle;
        errors_before = errors;
        idle = 0;
        // Writes stay back to back so dependent pairs go through forwarding
        if (!op.is_write)
            idle = $unsigned($random(seed)) % 4;
        repeat (idle) begin
            @(negedge clk);
            apb_req = '0;
        end
        apb_transfer(op, rdata, err);
        check_value(op.name, "pslverr", 32'(op.exp_err), 32'(err));
        if (!op.is_write)
            check_value(op.name, "prdata", op.exp_data, rdata);
        if (errors == errors_before) begin
            $display("%0s: pass", op.name);
        end else begin
            $display("%0s: FAIL", op.name);
            failed_tests++;
        end
    endtask

    initial begin
        seed = 82;
        errors = 0;
        failed_tests = 0;
        loaded = 1'b0;
        reset = 1'b1;
        apb_req = '0;
        load_trace();
        if (ops.size() == 0) begin
            $display("Error: no transactions could be read from %0s", TRACE_FILE);
            $display("CHECKS FAILED");
            $finish;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (ops[i])
            run_op(ops[i]);
        @(negedge clk);
        apb_req = '0;
        $display("Tests run: %0d, passed: %0d, failed: %0d, mismatches: %0d",
                 ops.size(), ops.size() - failed_tests, failed_tests, errors);
        if (failed_tests == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Watchdog sized from the trace length
    initial begin
        wait (loaded === 1'b1);
        repeat (RESET_CYCLES + ops.size() * CYCLES_PER_OP) @(posedge clk);
        $display("Timeout: the trace did not complete within %0d cycles",
                 RESET_CYCLES + ops.size() * CYCLES_PER_OP);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- rv_exec_top.f
src/rv_isa_pkg.sv
src/exec_bus_pkg.sv
src/apb_issue_port.sv
src/instr_decode_unit.sv
src/reg_file.sv
src/exe.sv
src/rv_exec_top.sv
test/tb_rv_exec_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_exec_top
FILELIST  = rv_exec_top.f
PASS_MSG  = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the trace and look for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- test/exec_trace.txt
# name  op(W/R)  addr  wdata  expected_rdata  expected_pslverr
# Register values are read at 0x080 + 4*r, STATUS is at 0x004
setup_x1     W 000 06400093 00000000 0
setup_x2     W 000 FF900113 00000000 0
setup_x3     W 000 00500193 00000000 0
r_add        W 000 00208233 00000000 0
r_sub        W 000 402082B3 00000000 0
r_and        W 000 0020F333 00000000 0
r_or         W 000 0020E3B3 00000000 0
r_xor        W 000 0020C433 00000000 0
r_sll        W 000 003094B3 00000000 0
r_srl        W 000 00315533 00000000 0
r_sra        W 000 403155B3 00000000 0
r_slt        W 000 00112633 00000000 0
r_sltu       W 000 001136B3 00000000 0
rd_add       R 090 00000000 0000005D 0
rd_sub       R 094 00000000 0000006B 0
rd_and       R 098 00000000 00000060 0
rd_or        R 09C 00000000 FFFFFFFD 0
rd_xor       R 0A0 00000000 FFFFFF9D 0
rd_sll       R 0A4 00000000 00000C80 0
rd_srl       R 0A8 00000000 07FFFFFF 0
rd_sra       R 0AC 00000000 FFFFFFFF 0
rd_slt       R 0B0 00000000 00000001 0
rd_sltu      R 0B4 00000000 00000000 0
i_addi_neg   W 000 F3808713 00000000 0
i_andi_neg   W 000 FF017793 00000000 0
i_xori_neg   W 000 FFF0C813 00000000 0
i_sltiu_neg  W 000 FFF0B893 00000000 0
i_srai_31    W 000 41F15913 00000000 0
i_slli_0     W 000 00009993 00000000 0
rd_addi      R 0B8 00000000 FFFFFF9C 0
rd_andi      R 0BC 00000000 FFFFFFF0 0
rd_xori      R 0C0 00000000 FFFFFF9B 0
rd_sltiu     R 0C4 00000000 00000001 0
rd_srai      R 0C8 00000000 FFFFFFFF 0
rd_slli      R 0CC 00000000 00000064 0
dep_addi     W 000 00108B13 00000000 0
dep_add      W 000 016B0BB3 00000000 0
dep_sub      W 000 401B8C33 00000000 0
rd_dep_add   R 0DC 00000000 000000CA 0
rd_dep_sub   R 0E0 00000000 00000066 0
x0_write     W 000 00508013 00000000 0
rd_x0        R 080 00000000 00000000 0
ill_mul      W 000 023100B3 00000000 0
rd_ill_x1    R 084 00000000 00000064 0
rd_status_1  R 004 00000000 00000001 0
clr_status   W 004 00000001 00000000 0
rd_status_0  R 004 00000000 00000000 0
err_reg_wr   W 084 12345678 00000000 1
rd_err_x1    R 084 00000000 00000064 0
err_rd_200   R 200 00000000 00000000 1
